/* Bender.yml */
package:
  name: muldiv

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/muldiv_pkg.sv
      - design/muldiv_lzc.sv
      - design/muldiv_decoder.sv
      - design/muldiv_multiplier.sv
      - design/muldiv_serdiv.sv
      - design/muldiv_rsp_arbiter.sv
      - design/muldiv_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_muldiv_top.sv

/* design/muldiv_decoder.sv */
/*
  Instruction decode and steering for the M unit. Non-M instructions are
  answered with an error response from a one-entry slot, data zero.
*/
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module muldiv_decoder (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [31:0]       req_instr_i,
  input  muldiv_pkg::id_t   req_id_i,
  output logic              mul_valid_o,
  input  logic              mul_ready_i,
  output logic              div_valid_o,
  input  logic              div_ready_i,
  output muldiv_pkg::rsp_t  err_rsp_o,
  output logic              err_valid_o,
  input  logic              err_ready_i
);

  logic                is_m;
  logic                is_mul;
  logic                is_div;
  logic                err_ready;
  logic                err_valid_q;
  muldiv_pkg::id_t     err_id_q;
  muldiv_pkg::funct3_t funct3;

  assign funct3 = req_instr_i[14:12];
  assign is_m   = (req_instr_i[6:0] == `MULDIV_OPCODE_OP) &&
                  (req_instr_i[31:25] == `MULDIV_FUNCT7_M);

  always_comb begin
    is_mul = 1'b0;
    is_div = 1'b0;
    unique case (funct3)
      `MULDIV_F3_MUL, `MULDIV_F3_MULH, `MULDIV_F3_MULHSU, `MULDIV_F3_MULHU: begin
        is_mul = is_m;
      end
      `MULDIV_F3_DIV, `MULDIV_F3_DIVU, `MULDIV_F3_REM, `MULDIV_F3_REMU: begin
        is_div = is_m;
      end
    endcase
  end

  assign mul_valid_o = req_valid_i & is_mul;
  assign div_valid_o = req_valid_i & is_div;

  // error slot takes a new entry when empty or draining
  assign err_ready   = ~err_valid_q | err_ready_i;
  assign req_ready_o = is_mul ? mul_ready_i :
                       is_div ? div_ready_i : err_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (err_ready) begin
      err_valid_q <= req_valid_i & ~is_m;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && !is_m && err_ready) begin
      err_id_q <= req_id_i;
    end
  end

  assign err_valid_o = err_valid_q;
  assign err_rsp_o   = '{data: '0, id: err_id_q, error: 1'b1};

endmodule

/* design/muldiv_lzc.sv */
/*
  Leading-zero counter over one word. cnt_o is zero and meaningless
  when empty_o is set.
*/
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module muldiv_lzc (
  input  muldiv_pkg::word_t                in_i,
  output logic [$clog2(`MULDIV_XLEN)-1:0]  cnt_o,
  output logic                             empty_o
);

  localparam int unsigned CntW = $clog2(`MULDIV_XLEN);

  // scan upward so the highest set bit wins
  always_comb begin
    cnt_o = '0;
    for (int i = 0; i < `MULDIV_XLEN; i++) begin
      if (in_i[i]) begin
        cnt_o = CntW'(`MULDIV_XLEN - 1 - i);
      end
    end
  end

  assign empty_o = ~|in_i;

endmodule

/* design/muldiv_multiplier.sv */
/*
  Single-stage 32x32 multiplier with one output register. Sustains one
  result per cycle while the consumer keeps up, and holds under stall.
*/
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module muldiv_multiplier (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  muldiv_pkg::req_t  req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output muldiv_pkg::rsp_t  rsp_o,
  output logic              valid_o,
  input  logic              ready_i
);

  logic                          sign_a;
  logic                          sign_b;
  logic                          upper_d;
  logic                          upper_q;
  logic                          valid_q;
  logic                          load;
  logic [2*`MULDIV_XLEN-1:0]     prod_d;
  logic [2*`MULDIV_XLEN-1:0]     prod_q;
  muldiv_pkg::id_t               id_q;

  // operand signedness per funct3, MUL only needs the low word
  assign sign_a  = (req_i.funct3 != `MULDIV_F3_MULHU);
  assign sign_b  = (req_i.funct3 == `MULDIV_F3_MUL) || (req_i.funct3 == `MULDIV_F3_MULH);
  assign upper_d = (req_i.funct3 != `MULDIV_F3_MUL);

  assign prod_d = $signed({sign_a & req_i.a[`MULDIV_XLEN-1], req_i.a}) *
                  $signed({sign_b & req_i.b[`MULDIV_XLEN-1], req_i.b});

  assign ready_o = ~valid_q | ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      prod_q  <= prod_d;
      id_q    <= req_i.id;
      upper_q <= upper_d;
    end
  end

  assign valid_o = valid_q;
  assign rsp_o   = '{data: upper_q ? prod_q[2*`MULDIV_XLEN-1:`MULDIV_XLEN]
                                   : prod_q[`MULDIV_XLEN-1:0],
                     id: id_q,
                     error: 1'b0};

  // a stalled result must not move
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(rsp_o));

endmodule

/* design/muldiv_pkg.sv */
/*
  Types shared by the multiply/divide unit. Widths come from the constants
  header, so the header must be on the include path.
*/
`include "muldiv_consts.svh"

package muldiv_pkg;

  // operands and results
  typedef logic [`MULDIV_XLEN-1:0] word_t;

  // transaction id as seen on the accelerator port
  typedef logic [`MULDIV_ID_W-1:0] id_t;

  // operation select inside one engine
  typedef logic [2:0] funct3_t;

  // request after decode
  typedef struct packed {
    id_t     id;
    funct3_t funct3;
    word_t   a;
    word_t   b;
  } req_t;

  // response of each engine and of the unit
  typedef struct packed {
    word_t data;
    id_t   id;
    logic  error;
  } rsp_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_DIVIDE,
    DIV_FINISH
  } div_state_e;

endpackage

/* design/muldiv_rsp_arbiter.sv */
/*
  Round-robin merge of three response streams, no added cycle.
  A grant stays locked on its input until the response is taken.
*/
`timescale 1ns/1ps

module muldiv_rsp_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  muldiv_pkg::rsp_t [2:0]  rsp_i,
  input  logic [2:0]              valid_i,
  output logic [2:0]              ready_o,
  output muldiv_pkg::rsp_t        rsp_o,
  output logic                    valid_o,
  input  logic                    ready_i
);

  logic [1:0] ptr_q;
  logic [1:0] gnt_q;
  logic [1:0] gnt;
  logic [1:0] cand;
  logic       lock_q;
  logic       found;

  function automatic logic [1:0] next_idx(input logic [1:0] idx);
    return (idx == 2'd2) ? 2'd0 : idx + 2'd1;
  endfunction

  // first valid input at or after the pointer
  always_comb begin
    gnt   = ptr_q;
    cand  = ptr_q;
    found = 1'b0;
    for (int k = 0; k < 3; k++) begin
      if (!found && valid_i[cand]) begin
        found = 1'b1;
        gnt   = cand;
      end
      cand = next_idx(cand);
    end
    if (lock_q) begin
      gnt = gnt_q;
    end
  end

  assign valid_o = valid_i[gnt];
  assign rsp_o   = rsp_i[gnt];

  always_comb begin
    ready_o      = '0;
    ready_o[gnt] = ready_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q  <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (valid_o) begin
      lock_q <= ~ready_i;
      gnt_q  <= gnt;
      if (ready_i) begin
        ptr_q <= next_idx(gnt);
      end
    end
  end

  a_grant_locked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> gnt == $past(gnt));

endmodule

/* design/muldiv_serdiv.sv */
/*
  Serial restoring divider on operand magnitudes, one quotient bit per cycle.
  The divisor is pre-aligned to the dividend, so latency is 1 to 33 cycles.
  Holds a single operation; zero divisor and overflow follow RISC-V.
*/
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module muldiv_serdiv (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  muldiv_pkg::req_t  req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output muldiv_pkg::rsp_t  rsp_o,
  output logic              valid_o,
  input  logic              ready_i
);

  localparam int unsigned CntW = $clog2(`MULDIV_XLEN);

  muldiv_pkg::div_state_e state_d;
  muldiv_pkg::div_state_e state_q;

  logic              signed_op;
  logic              rem_op;
  logic              sign_a;
  logic              sign_b;
  muldiv_pkg::word_t abs_a;
  muldiv_pkg::word_t abs_b;
  logic [CntW-1:0]   lz_a;
  logic [CntW-1:0]   lz_b;
  logic              empty_a;
  logic              empty_b;
  logic              early;
  logic [CntW-1:0]   shift;
  logic              load;
  logic              fits;

  muldiv_pkg::word_t rem_q;
  muldiv_pkg::word_t dvs_q;
  muldiv_pkg::word_t quo_q;
  logic [CntW-1:0]   cnt_q;
  muldiv_pkg::id_t   id_q;
  logic              rem_sel_q;
  logic              quo_inv_q;
  logic              rem_inv_q;
  logic              b_zero_q;
  muldiv_pkg::word_t quo_out;
  muldiv_pkg::word_t rem_out;

  ////////////////////////////////////////////////////////////////////////////
  // operand magnitudes and alignment
  ////////////////////////////////////////////////////////////////////////////

  assign signed_op = (req_i.funct3 == `MULDIV_F3_DIV) || (req_i.funct3 == `MULDIV_F3_REM);
  assign rem_op    = (req_i.funct3 == `MULDIV_F3_REM) || (req_i.funct3 == `MULDIV_F3_REMU);
  assign sign_a    = signed_op & req_i.a[`MULDIV_XLEN-1];
  assign sign_b    = signed_op & req_i.b[`MULDIV_XLEN-1];

  // most negative value maps onto 2^31, still correct as unsigned
  assign abs_a = sign_a ? -req_i.a : req_i.a;
  assign abs_b = sign_b ? -req_i.b : req_i.b;

  muldiv_lzc u_lzc_a (
    .in_i    (abs_a),
    .cnt_o   (lz_a),
    .empty_o (empty_a)
  );

  muldiv_lzc u_lzc_b (
    .in_i    (abs_b),
    .cnt_o   (lz_b),
    .empty_o (empty_b)
  );

  // |b| > |a|, a zero or b zero: nothing to iterate
  assign early = empty_a | empty_b | (lz_b < lz_a);
  assign shift = lz_b - lz_a;
  assign load  = valid_i & ready_o;
  assign fits  = (rem_q >= dvs_q);

  ////////////////////////////////////////////////////////////////////////////
  // FSM and counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      muldiv_pkg::DIV_IDLE: begin
        if (valid_i) begin
          state_d = early ? muldiv_pkg::DIV_FINISH : muldiv_pkg::DIV_DIVIDE;
        end
      end
      muldiv_pkg::DIV_DIVIDE: begin
        if (cnt_q == '0) begin
          state_d = muldiv_pkg::DIV_FINISH;
        end
      end
      muldiv_pkg::DIV_FINISH: begin
        if (ready_i) begin
          state_d = muldiv_pkg::DIV_IDLE;
        end
      end
      default: state_d = muldiv_pkg::DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= muldiv_pkg::DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        cnt_q <= shift;
      end else if (state_q == muldiv_pkg::DIV_DIVIDE && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (load) begin
      rem_q     <= abs_a;
      dvs_q     <= abs_b << shift;
      quo_q     <= '0;
      id_q      <= req_i.id;
      rem_sel_q <= rem_op;
      quo_inv_q <= sign_a ^ sign_b;
      rem_inv_q <= sign_a;
      b_zero_q  <= empty_b;
    end else if (state_q == muldiv_pkg::DIV_DIVIDE) begin
      if (fits) begin
        rem_q <= rem_q - dvs_q;
      end
      quo_q <= {quo_q[`MULDIV_XLEN-2:0], fits};
      dvs_q <= dvs_q >> 1;
    end
  end

  // zero divisor: all ones, remainder comes back as a through rem_inv
  assign quo_out = b_zero_q  ? '1 :
                   quo_inv_q ? -quo_q : quo_q;
  assign rem_out = rem_inv_q ? -rem_q : rem_q;

  assign ready_o = (state_q == muldiv_pkg::DIV_IDLE);
  assign valid_o = (state_q == muldiv_pkg::DIV_FINISH);
  assign rsp_o   = '{data: rem_sel_q ? rem_out : quo_out, id: id_q, error: 1'b0};

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {muldiv_pkg::DIV_IDLE, muldiv_pkg::DIV_DIVIDE, muldiv_pkg::DIV_FINISH});

  // ready only comes back once the held result is taken
  a_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ready_o) |-> $past(valid_o && ready_i));

endmodule

/* design/muldiv_top.sv */
/*
  RV32 M-extension unit behind a valid/ready accelerator port.
  Responses may return out of order; match them by id.
*/
`timescale 1ns/1ps

module muldiv_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  logic [31:0]        req_instr_i,
  input  muldiv_pkg::id_t    req_id_i,
  input  muldiv_pkg::word_t  req_a_i,
  input  muldiv_pkg::word_t  req_b_i,
  output muldiv_pkg::rsp_t   rsp_o,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i
);

  muldiv_pkg::req_t req;
  muldiv_pkg::rsp_t mul_rsp;
  muldiv_pkg::rsp_t div_rsp;
  muldiv_pkg::rsp_t err_rsp;
  logic             mul_valid_in;
  logic             mul_ready_in;
  logic             div_valid_in;
  logic             div_ready_in;
  logic [2:0]       arb_valid;
  logic [2:0]       arb_ready;

  assign req = '{id: req_id_i, funct3: req_instr_i[14:12], a: req_a_i, b: req_b_i};

  muldiv_decoder u_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_instr_i (req_instr_i),
    .req_id_i    (req_id_i),
    .mul_valid_o (mul_valid_in),
    .mul_ready_i (mul_ready_in),
    .div_valid_o (div_valid_in),
    .div_ready_i (div_ready_in),
    .err_rsp_o   (err_rsp),
    .err_valid_o (arb_valid[2]),
    .err_ready_i (arb_ready[2])
  );

  muldiv_multiplier u_mul (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req),
    .valid_i (mul_valid_in),
    .ready_o (mul_ready_in),
    .rsp_o   (mul_rsp),
    .valid_o (arb_valid[1]),
    .ready_i (arb_ready[1])
  );

  muldiv_serdiv u_div (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req),
    .valid_i (div_valid_in),
    .ready_o (div_ready_in),
    .rsp_o   (div_rsp),
    .valid_o (arb_valid[0]),
    .ready_i (arb_ready[0])
  );

  // index 0 divider, 1 multiplier, 2 error slot
  muldiv_rsp_arbiter u_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rsp_i   ({err_rsp, mul_rsp, div_rsp}),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .rsp_o   (rsp_o),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i)
  );

  // the host must hold a pending request
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_o |=>
      req_valid_i && $stable({req_instr_i, req_id_i, req_a_i, req_b_i}));

endmodule

/* include/muldiv_consts.svh */
/*
  Constants of the RV32 M-extension unit. Only 32-bit operation is supported,
  and the id width must match the accelerator port of the host core.
*/
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// operand and id widths
`define MULDIV_XLEN 32
`define MULDIV_ID_W 5

// major opcode and funct7 shared by all M instructions
`define MULDIV_OPCODE_OP 7'b0110011
`define MULDIV_FUNCT7_M  7'b0000001

// funct3 codes
`define MULDIV_F3_MUL    3'b000
`define MULDIV_F3_MULH   3'b001
`define MULDIV_F3_MULHSU 3'b010
`define MULDIV_F3_MULHU  3'b011
`define MULDIV_F3_DIV    3'b100
`define MULDIV_F3_DIVU   3'b101
`define MULDIV_F3_REM    3'b110
`define MULDIV_F3_REMU   3'b111

`endif

/* muldiv_top.f */
+incdir+include
design/muldiv_pkg.sv
design/muldiv_lzc.sv
design/muldiv_decoder.sv
design/muldiv_multiplier.sv
design/muldiv_serdiv.sv
design/muldiv_rsp_arbiter.sv
design/muldiv_top.sv
tb/tb_muldiv_top.sv

/* tb/muldiv_cases.txt */
# kind a b expected error, all values in hex
# error is 1 when the instruction is not an M instruction
mul 00000007 00000006 0000002a 0
mul fffffffd 00000005 fffffff1 0
mul 00010001 00010001 00020001 0
mulh 80000000 80000000 40000000 0
mulh fffffffe 00000003 ffffffff 0
mulh 00010000 00010000 00000001 0
mulhsu ffffffff ffffffff ffffffff 0
mulhsu 00000002 80000000 00000001 0
mulhsu 80000000 00000002 ffffffff 0
mulhu ffffffff ffffffff fffffffe 0
mulhu 80000000 00000004 00000002 0
divu ffffffff 00000001 ffffffff 0
mul 00000003 00000003 00000009 0
div 00000064 00000007 0000000e 0
div ffffff9c 00000007 fffffff2 0
div 00000064 fffffff9 fffffff2 0
div 00000003 00000007 00000000 0
rem ffffff9c 00000007 fffffffe 0
rem 00000064 fffffff9 00000002 0
rem fffffffd 00000007 fffffffd 0
divu 00000005 00000009 00000000 0
remu 00000064 00000007 00000002 0
remu ffffffff 00000010 0000000f 0
div 00000005 00000000 ffffffff 0
divu 00000005 00000000 ffffffff 0
rem fffffff6 00000000 fffffff6 0
remu 00000009 00000000 00000009 0
div 80000000 ffffffff 80000000 0
rem 80000000 ffffffff 00000000 0
add 00000001 00000002 00000000 1
load 00000001 00000002 00000000 1

/* tb/tb_muldiv_top.sv */
/*
  Testbench for the M unit. Reads tb/muldiv_cases.txt relative to the project
  root. Responses are matched by id, so at most 32 requests may be in flight.
*/
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module tb_muldiv_top;

  localparam int NumIds     = 2 ** `MULDIV_ID_W;
  localparam int ReqTimeout = 500;
  localparam int EndTimeout = 5000;

  logic              clk_i;
  logic              rst_ni;
  logic              req_valid_i;
  logic              req_ready_o;
  logic [31:0]       req_instr_i;
  muldiv_pkg::id_t   req_id_i;
  muldiv_pkg::word_t req_a_i;
  muldiv_pkg::word_t req_b_i;
  muldiv_pkg::rsp_t  rsp_o;
  logic              rsp_valid_o;
  logic              rsp_ready_i;

  // expected response per id
  muldiv_pkg::word_t exp_data  [NumIds];
  logic              exp_err   [NumIds];
  logic              pending   [NumIds];
  string             case_name [NumIds];
  int                issued;
  int                received;
  integer            seed = 36162;

  muldiv_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_instr_i (req_instr_i),
    .req_id_i    (req_id_i),
    .req_a_i     (req_a_i),
    .req_b_i     (req_b_i),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input muldiv_pkg::word_t exp,
                            input muldiv_pkg::word_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s data: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s error: expected %b, actual %b", name, exp, act));
    end
  endtask

  // R-type encoding with rd=x3, rs1=x1, rs2=x2
  function automatic logic build_instr(input string kind, output logic [31:0] instr);
    logic [6:0] f7;
    logic [6:0] op;
    logic [2:0] f3;
    f7 = `MULDIV_FUNCT7_M;
    op = `MULDIV_OPCODE_OP;
    case (kind)
      "mul":    f3 = `MULDIV_F3_MUL;
      "mulh":   f3 = `MULDIV_F3_MULH;
      "mulhsu": f3 = `MULDIV_F3_MULHSU;
      "mulhu":  f3 = `MULDIV_F3_MULHU;
      "div":    f3 = `MULDIV_F3_DIV;
      "divu":   f3 = `MULDIV_F3_DIVU;
      "rem":    f3 = `MULDIV_F3_REM;
      "remu":   f3 = `MULDIV_F3_REMU;
      "add": begin
        f7 = 7'b0000000;
        f3 = 3'b000;
      end
      // M funct7 on a load opcode, still illegal here
      "load": begin
        op = 7'b0000011;
        f3 = 3'b010;
      end
      default: begin
        instr = '0;
        return 1'b0;
      end
    endcase
    instr = {f7, 5'd2, 5'd1, f3, 5'd3, op};
    return 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_req(input muldiv_pkg::id_t id, input logic [31:0] instr,
                          input muldiv_pkg::word_t a, input muldiv_pkg::word_t b);
    int   cycles;
    logic done;
    cycles      = 0;
    done        = 1'b0;
    req_valid_i = 1'b1;
    req_instr_i = instr;
    req_id_i    = id;
    req_a_i     = a;
    req_b_i     = b;
    while (!done) begin
      @(negedge clk_i);
      if (req_ready_o) begin
        done = 1'b1;
      end else begin
        cycles++;
        if (cycles > ReqTimeout) begin
          fail_run($sformatf("request with id %0d was never accepted", id));
        end
      end
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_id_free(input muldiv_pkg::id_t id);
    int cycles;
    cycles = 0;
    while (pending[id]) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > EndTimeout) begin
        fail_run($sformatf("id %0d never returned, cannot reuse it", id));
      end
    end
  endtask

  // random back-pressure on the response port
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      rsp_ready_i = (($random(seed) & 3) != 0);
    end
  end

  // a transfer seen at the falling edge completes at the next rising edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && rsp_valid_o && rsp_ready_i) begin
        if (!pending[rsp_o.id]) begin
          fail_run($sformatf("response with id %0d that is not outstanding", rsp_o.id));
        end
        check_error(case_name[rsp_o.id], exp_err[rsp_o.id], rsp_o.error);
        check_data(case_name[rsp_o.id], exp_data[rsp_o.id], rsp_o.data);
        pending[rsp_o.id] = 1'b0;
        received++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                fd;
    int                code;
    int                ch;
    int                waited;
    string             kind;
    muldiv_pkg::word_t a;
    muldiv_pkg::word_t b;
    muldiv_pkg::word_t exp;
    logic              err;
    logic [31:0]       instr;
    muldiv_pkg::id_t   id;

    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_instr_i = '0;
    req_id_i    = '0;
    req_a_i     = '0;
    req_b_i     = '0;
    rsp_ready_i = 1'b0;
    issued      = 0;
    received    = 0;
    for (int i = 0; i < NumIds; i++) begin
      pending[i] = 1'b0;
    end

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    fd = $fopen("tb/muldiv_cases.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open tb/muldiv_cases.txt");
    end
    id   = '0;
    code = $fscanf(fd, " %s", kind);
    while (code == 1) begin
      if (kind == "#") begin
        // skip the rest of a comment line
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        code = $fscanf(fd, " %h %h %h %h", a, b, exp, err);
        if (code != 4) begin
          fail_run($sformatf("case %0d (%s) has a malformed line", issued, kind));
        end
        if (!build_instr(kind, instr)) begin
          fail_run($sformatf("case %0d has an unknown kind %s", issued, kind));
        end
        wait_id_free(id);
        case_name[id] = $sformatf("%s_%0d", kind, issued);
        exp_data[id]  = exp;
        exp_err[id]   = err;
        pending[id]   = 1'b1;
        issued++;
        send_req(id, instr, a, b);
        id = id + 1'b1;
      end
      code = $fscanf(fd, " %s", kind);
    end
    $fclose(fd);

    waited = 0;
    while (received != issued && waited < EndTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (received == issued && issued > 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run($sformatf("only %0d of %0d responses returned", received, issued));
    end
  end

endmodule
